//--- common/noc_params.svh
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// --------------------
// Router size

`define NOC_PORTS 5
`define NOC_PORT_W 3

// --------------------
// Flit fields

`define NOC_KIND_W 2
`define NOC_LEN_W 12
`define NOC_DATA_W 16

// --------------------
// Input buffering

`define NOC_FIFO_DEPTH 8  // One FIFO holds the longest packet
`define NOC_PTR_W 3
`define NOC_CNT_W 4

`endif

//--- common/nocFlitPkg.sv
`include "noc_params.svh"

package nocFlitPkg;

  // --------------------
  // Flit kinds

  typedef enum logic [`NOC_KIND_W-1:0]
  {
    HEAD   = 2'd0,
    BODY   = 2'd1,
    TAIL   = 2'd2,
    SINGLE = 2'd3  // Head and tail in one flit
  } flitKind;

  // --------------------
  // Link words

  typedef struct packed
  {
    flitKind                kind;
    logic [`NOC_LEN_W-1:0]  length;   // Valid in HEAD and SINGLE only
    logic [`NOC_DATA_W-1:0] payload;
  } linkFlit;

  typedef struct packed
  {
    flitKind                kind;
    logic [`NOC_PORT_W-1:0] srcPort;  // Input port the flit came from
    logic [`NOC_LEN_W-1:0]  length;
    logic [`NOC_DATA_W-1:0] payload;
  } outFlit;

endpackage

//--- common/nocArbPkg.sv
`include "noc_params.svh"

package nocArbPkg;

  typedef enum logic [`NOC_PORT_W-1:0]
  {
    LOCAL = 3'd0,
    NORTH = 3'd1,
    EAST  = 3'd2,
    WEST  = 3'd3,
    SOUTH = 3'd4
  } portId;

  typedef enum logic [2:0]
  {
    IDLE   = 3'd0,
    HOLD_L = 3'd1,
    HOLD_N = 3'd2,
    HOLD_E = 3'd3,
    HOLD_W = 3'd4,
    HOLD_S = 3'd5
  } arbState;

  // Port that owns the output in a HOLD state
  function automatic portId holderPort(arbState s);
    case (s)
      HOLD_N: return NORTH;
      HOLD_E: return EAST;
      HOLD_W: return WEST;
      HOLD_S: return SOUTH;
      default: return LOCAL;
    endcase
  endfunction

  function automatic arbState holdOf(portId p);
    case (p)
      NORTH: return HOLD_N;
      EAST: return HOLD_E;
      WEST: return HOLD_W;
      SOUTH: return HOLD_S;
      default: return HOLD_L;
    endcase
  endfunction

endpackage

//--- hw/inputPort.sv
`timescale 1ns/1ps
`include "noc_params.svh"

module inputPort
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inReq,
  output logic                  inAck,
  input  nocFlitPkg::linkFlit   inFlit,
  input  logic                  pop,
  output logic                  pktReq,
  output logic [`NOC_LEN_W-1:0] headLen,
  output nocFlitPkg::linkFlit   headFlit
);

  nocFlitPkg::linkFlit mem [`NOC_FIFO_DEPTH];

  logic [`NOC_PTR_W-1:0] wrPtr;
  logic [`NOC_PTR_W-1:0] rdPtr;
  logic [`NOC_CNT_W-1:0] fill;
  logic [`NOC_CNT_W-1:0] pktCnt;   // Complete packets held in the FIFO
  logic [`NOC_LEN_W-1:0] flitCnt;  // Flits received of the packet still arriving
  logic [`NOC_LEN_W-1:0] pktLen;
  logic [`NOC_LEN_W-1:0] curCnt;
  logic [`NOC_LEN_W-1:0] curLen;
  logic                  full;
  logic                  wrEn;
  logic                  isHead;
  logic                  lastIn;
  logic                  lastOut;

  // --------------------
  // Four-phase receiver

  assign full = (fill == `NOC_CNT_W'(`NOC_FIFO_DEPTH));
  assign wrEn = inReq && !inAck && !full;  // Flit is stored on the edge that raises ack

  always_ff @(posedge clk)
  begin
    if (rst)
      inAck <= 1'b0;
    else if (wrEn)
      inAck <= 1'b1;
    else if (inAck && !inReq)
      inAck <= 1'b0;
  end

  // --------------------
  // Packet tracking

  assign isHead = (inFlit.kind == nocFlitPkg::HEAD) || (inFlit.kind == nocFlitPkg::SINGLE);
  assign curCnt = isHead ? `NOC_LEN_W'(1) : flitCnt + 1'b1;
  assign curLen = isHead ? inFlit.length : pktLen;
  assign lastIn = wrEn && (curCnt == curLen);
  assign lastOut = pop && ((headFlit.kind == nocFlitPkg::TAIL) ||
                           (headFlit.kind == nocFlitPkg::SINGLE));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill <= '0;
      pktCnt <= '0;
      flitCnt <= '0;
    end
    else
    begin
      if (wrEn)
      begin
        wrPtr <= wrPtr + 1'b1;
        flitCnt <= lastIn ? '0 : curCnt;
      end
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      case ({wrEn, pop})
        2'b10: fill <= fill + 1'b1;
        2'b01: fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      case ({lastIn, lastOut})
        2'b10: pktCnt <= pktCnt + 1'b1;
        2'b01: pktCnt <= pktCnt - 1'b1;
        default: pktCnt <= pktCnt;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (wrEn)
    begin
      mem[wrPtr] <= inFlit;
      pktLen <= curLen;
    end
  end

  // Whole packets only leave from the front, so the front is always a head when requesting
  assign headFlit = mem[rdPtr];
  assign headLen = headFlit.length;
  assign pktReq = (pktCnt != '0);

endmodule

//--- arbiter/switchArbiter.sv
`timescale 1ns/1ps
`include "noc_params.svh"

module switchArbiter
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [`NOC_PORTS-1:0]                 pktReq,
  input  logic [`NOC_PORTS-1:0][`NOC_LEN_W-1:0] headLen,
  input  logic                                  pop,
  output nocArbPkg::arbState                    grant
);

  nocArbPkg::arbState    nextGrant;
  nocArbPkg::portId      holder;
  nocArbPkg::portId      winner;
  logic                  found;
  logic                  stay;
  logic                  timesUp;
  logic                  loadTimer;
  logic [`NOC_LEN_W-1:0] grantCnt;  // Flits sent in the current grant
  logic [`NOC_LEN_W-1:0] grantLen;

  assign holder = nocArbPkg::holderPort(grant);
  assign timesUp = (grantCnt == grantLen);
  assign stay = (grant != nocArbPkg::IDLE) && pktReq[holder] && !timesUp;

  // --------------------
  // Rotating search

  always_comb
  begin
    int unsigned start;
    int unsigned cand;
    found = 1'b0;
    winner = nocArbPkg::LOCAL;
    if (grant == nocArbPkg::IDLE)
      start = 0;
    else
      start = (int'(holder) + 1) % `NOC_PORTS;
    // Walk from the far end so the port nearest the start is taken last
    for (int i = `NOC_PORTS - 1; i >= 0; i--)
    begin
      cand = (start + i) % `NOC_PORTS;
      if (pktReq[cand])
      begin
        found = 1'b1;
        winner = nocArbPkg::portId'(cand);
      end
    end
  end

  always_comb
  begin
    if (stay)
      nextGrant = grant;
    else if (found)
      nextGrant = nocArbPkg::holdOf(winner);  // May be the holder again if nobody else asks
    else
      nextGrant = nocArbPkg::IDLE;
  end

  assign loadTimer = !stay && found;

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= nocArbPkg::IDLE;
    else
      grant <= nextGrant;
  end

  // --------------------
  // Grant timer

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grantCnt <= '0;
      grantLen <= '0;
    end
    else if (loadTimer)
    begin
      grantCnt <= '0;
      grantLen <= headLen[winner];  // Length of the packet about to be sent
    end
    else if (pop)
      grantCnt <= grantCnt + 1'b1;
  end

endmodule

//--- hw/outputLink.sv
`timescale 1ns/1ps
`include "noc_params.svh"

module outputLink
(
  input  logic                                clk,
  input  logic                                rst,
  input  nocArbPkg::arbState                  grant,
  input  nocFlitPkg::linkFlit [`NOC_PORTS-1:0] headFlit,
  output logic                                outReq,
  input  logic                                outAck,
  output nocFlitPkg::outFlit                  outData,
  output logic [`NOC_PORTS-1:0]               pop
);

  typedef enum logic [1:0]
  {
    LINK_IDLE,
    LINK_REQ,   // Flit offered, waiting for ack
    LINK_WAIT   // Flit taken, waiting for ack to drop
  } linkState;

  linkState            state;
  nocArbPkg::portId    src;
  nocFlitPkg::linkFlit front;

  assign src = nocArbPkg::holderPort(grant);
  assign front = headFlit[src];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= LINK_IDLE;
      outReq <= 1'b0;
      pop <= '0;
    end
    else
    begin
      pop <= '0;
      case (state)
        LINK_IDLE:
        begin
          if (grant != nocArbPkg::IDLE)
          begin
            outReq <= 1'b1;
            state <= LINK_REQ;
          end
        end
        LINK_REQ:
        begin
          if (outAck)
          begin
            outReq <= 1'b0;
            pop[src] <= 1'b1;  // Grant cannot move while a flit is in flight
            state <= LINK_WAIT;
          end
        end
        default:
        begin
          if (!outAck && pop == '0)  // The arbiter sees the pop before the next flit
            state <= LINK_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == LINK_IDLE && grant != nocArbPkg::IDLE)
    begin
      outData.kind <= front.kind;
      outData.srcPort <= src;
      outData.length <= front.length;
      outData.payload <= front.payload;
    end
  end

endmodule

//--- hw/nocRouterOut.sv
`timescale 1ns/1ps
`include "noc_params.svh"

module nocRouterOut
(
  input  logic                                clk,
  input  logic                                rst,
  input  logic [`NOC_PORTS-1:0]               inReq,
  output logic [`NOC_PORTS-1:0]               inAck,
  input  nocFlitPkg::linkFlit [`NOC_PORTS-1:0] inFlit,
  output logic                                outReq,
  input  logic                                outAck,
  output nocFlitPkg::outFlit                  outData
);

  logic [`NOC_PORTS-1:0]                 pktReq;
  logic [`NOC_PORTS-1:0][`NOC_LEN_W-1:0] headLen;
  nocFlitPkg::linkFlit [`NOC_PORTS-1:0]   headFlit;
  nocArbPkg::arbState                    grant;
  logic [`NOC_PORTS-1:0]                 pop;

  // --------------------
  // Input ports

  for (genvar p = 0; p < `NOC_PORTS; p++)  // Index order matches nocArbPkg::portId
  begin : gPort
    inputPort i_port
    (
      .clk      (clk),
      .rst      (rst),
      .inReq    (inReq[p]),
      .inAck    (inAck[p]),
      .inFlit   (inFlit[p]),
      .pop      (pop[p]),
      .pktReq   (pktReq[p]),
      .headLen  (headLen[p]),
      .headFlit (headFlit[p])
    );
  end

  switchArbiter i_arb
  (
    .clk     (clk),
    .rst     (rst),
    .pktReq  (pktReq),
    .headLen (headLen),
    .pop     (|pop),
    .grant   (grant)
  );

  outputLink i_link
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .headFlit (headFlit),
    .outReq   (outReq),
    .outAck   (outAck),
    .outData  (outData),
    .pop      (pop)
  );

endmodule

//--- verif/tbNocRouterOut.sv
`timescale 1ns/1ps
`include "noc_params.svh"

module tbNocRouterOut;

  localparam int PKTS = 12;     // Packets per port with a fast output
  localparam int BP_PKTS = 4;   // Packets per port with a slow output
  localparam int FAST_PKTS = `NOC_PORTS * PKTS + `NOC_PORTS + 3;
  // Slow flits need up to about 28 cycles each, the rest is margin
  localparam int WATCHDOG_CYCLES = FAST_PKTS * 8 * 12 + `NOC_PORTS * BP_PKTS * 8 * 28 + 2000;

  logic                                 clk;
  logic                                 rst;
  logic [`NOC_PORTS-1:0]                inReq;
  logic [`NOC_PORTS-1:0]                inAck;
  nocFlitPkg::linkFlit [`NOC_PORTS-1:0] inFlit;
  logic                                 outReq;
  logic                                 outAck;
  nocFlitPkg::outFlit                   outData;

  nocFlitPkg::linkFlit model [`NOC_PORTS][$];  // Flits sent but not yet seen, per port
  int                  headOrder [$];          // Source port of each packet on the output
  string               testName;
  int                  errors;
  int                  txCount;
  int                  rxCount;
  logic                ackHold;
  int                  ackMin;
  int                  ackMax;
  logic                inPkt;
  int                  pktSrc;

  nocRouterOut i_dut
  (
    .clk     (clk),
    .rst     (rst),
    .inReq   (inReq),
    .inAck   (inAck),
    .inFlit  (inFlit),
    .outReq  (outReq),
    .outAck  (outAck),
    .outData (outData)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // Upstream senders

  task automatic handshakeFlit(input int p, input nocFlitPkg::linkFlit f);
    @(posedge clk);
    inFlit[p] <= f;
    inReq[p] <= 1'b1;
    @(negedge clk);
    while (!inAck[p])
      @(negedge clk);
    @(posedge clk);
    inReq[p] <= 1'b0;
    @(negedge clk);
    while (inAck[p])
      @(negedge clk);
  endtask

  task automatic sendPacket(input int p, input int len);
    nocFlitPkg::linkFlit f;
    for (int i = 0; i < len; i++)
    begin
      if (len == 1)
        f.kind = nocFlitPkg::SINGLE;
      else if (i == 0)
        f.kind = nocFlitPkg::HEAD;
      else if (i == len - 1)
        f.kind = nocFlitPkg::TAIL;
      else
        f.kind = nocFlitPkg::BODY;
      f.length = (i == 0) ? `NOC_LEN_W'(len) : '0;  // Only the first flit carries the length
      f.payload = `NOC_DATA_W'($urandom);
      model[p].push_back(f);
      txCount++;
      handshakeFlit(p, f);
    end
  endtask

  task automatic portTraffic(input int p, input int n);
    repeat (n)
    begin
      repeat ($urandom % 6)
        @(posedge clk);
      sendPacket(p, 1 + $urandom % 8);
    end
  endtask

  // --------------------
  // Checks

  task automatic expectIdle();
    if (outReq !== 1'b0 || inAck !== '0)
    begin
      errors++;
      $display("error %s: expected outReq 0 inAck %b actual outReq %b inAck %b",
               testName, 5'b0, outReq, inAck);
    end
  endtask

  task automatic checkFlit(input nocFlitPkg::outFlit got);
    nocFlitPkg::linkFlit exp;
    nocFlitPkg::linkFlit act;
    int src;
    src = int'(got.srcPort);
    act.kind = got.kind;
    act.length = got.length;
    act.payload = got.payload;
    rxCount++;
    if (src >= `NOC_PORTS)
    begin
      errors++;
      $display("%s: output flit carries an unknown source port %0d", testName, src);
    end
    else
    begin
      if (inPkt && src != pktSrc)
      begin
        errors++;
        $display("error %s: expected srcPort %0d actual %0d", testName, pktSrc, src);
      end
      if (act.kind == nocFlitPkg::HEAD || act.kind == nocFlitPkg::SINGLE)
        headOrder.push_back(src);
      if (act.kind == nocFlitPkg::HEAD)
      begin
        inPkt = 1'b1;
        pktSrc = src;
      end
      else if (act.kind == nocFlitPkg::TAIL || act.kind == nocFlitPkg::SINGLE)
        inPkt = 1'b0;
      if (model[src].size() == 0)
      begin
        errors++;
        $display("%s: port %0d delivered a flit that was never sent", testName, src);
      end
      else
      begin
        exp = model[src].pop_front();
        if (act != exp)
        begin
          errors++;
          $display("error %s: port %0d expected %h actual %h", testName, src, exp, act);
        end
      end
    end
  endtask

  task automatic compareOrder(input int want [$]);
    if (headOrder.size() != want.size())
    begin
      errors++;
      $display("error %s: expected %0d packets actual %0d",
               testName, want.size(), headOrder.size());
    end
    else
    begin
      foreach (want[i])
      begin
        if (headOrder[i] != want[i])
        begin
          errors++;
          $display("error %s: packet %0d expected port %0d actual %0d",
                   testName, i, want[i], headOrder[i]);
        end
      end
    end
  endtask

  task automatic drainOutput();
    while (rxCount < txCount)
      @(negedge clk);
    @(negedge clk);
    while (outReq || outAck)
      @(negedge clk);
    repeat (4)
      @(negedge clk);
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      if (model[p].size() != 0)
      begin
        errors++;
        $display("%s: port %0d has %0d flits that never reached the output",
                 testName, p, model[p].size());
      end
    end
  endtask

  // --------------------
  // Output receiver

  initial
  begin
    int ackDelay;
    forever
    begin
      @(negedge clk);
      if (outReq === 1'b1 && !rst)
      begin
        checkFlit(outData);
        while (ackHold)
          @(negedge clk);
        ackDelay = ackMin + int'($urandom % (ackMax - ackMin + 1));
        repeat (ackDelay)
          @(negedge clk);
        @(posedge clk);
        outAck <= 1'b1;
        @(negedge clk);
        while (outReq)
          @(negedge clk);
        @(posedge clk);
        outAck <= 1'b0;
      end
    end
  end

  // --------------------
  // Test sequence

  initial
  begin
    int want [$];
    void'($urandom(74524));
    rst = 1'b1;
    inReq = '0;
    inFlit = '0;
    outAck = 1'b0;
    errors = 0;
    txCount = 0;
    rxCount = 0;
    ackHold = 1'b0;
    ackMin = 0;
    ackMax = 3;
    inPkt = 1'b0;
    pktSrc = 0;

    testName = "reset";
    repeat (16)
    begin
      @(negedge clk);
      expectIdle();
    end
    @(posedge clk);
    rst <= 1'b0;
    repeat (2)
    begin
      @(negedge clk);
      expectIdle();
    end

    testName = "random";
    fork
      portTraffic(0, PKTS);
      portTraffic(1, PKTS);
      portTraffic(2, PKTS);
      portTraffic(3, PKTS);
      portTraffic(4, PKTS);
    join
    drainOutput();

    // Local is granted first, the rest must follow in rotation
    testName = "rotation";
    ackHold = 1'b1;
    headOrder.delete();
    sendPacket(int'(nocArbPkg::LOCAL), 1 + $urandom % 8);
    repeat (4)
      @(posedge clk);
    fork
      sendPacket(int'(nocArbPkg::NORTH), 1 + $urandom % 8);
      sendPacket(int'(nocArbPkg::EAST), 1 + $urandom % 8);
      sendPacket(int'(nocArbPkg::WEST), 1 + $urandom % 8);
      sendPacket(int'(nocArbPkg::SOUTH), 1 + $urandom % 8);
    join
    repeat (4)
      @(posedge clk);
    ackHold = 1'b0;
    drainOutput();
    want = '{0, 1, 2, 3, 4};
    compareOrder(want);

    // Two short North packets fit the FIFO together
    testName = "grantEnd";
    ackHold = 1'b1;
    headOrder.delete();
    sendPacket(int'(nocArbPkg::NORTH), 1 + $urandom % 4);
    repeat (4)
      @(posedge clk);
    fork
      sendPacket(int'(nocArbPkg::NORTH), 1 + $urandom % 4);
      sendPacket(int'(nocArbPkg::EAST), 1 + $urandom % 8);
    join
    repeat (4)
      @(posedge clk);
    ackHold = 1'b0;
    drainOutput();
    want = '{int'(nocArbPkg::NORTH), int'(nocArbPkg::EAST), int'(nocArbPkg::NORTH)};
    compareOrder(want);

    testName = "backpressure";
    ackMin = 10;
    ackMax = 20;
    fork
      portTraffic(0, BP_PKTS);
      portTraffic(1, BP_PKTS);
      portTraffic(2, BP_PKTS);
      portTraffic(3, BP_PKTS);
      portTraffic(4, BP_PKTS);
    join
    drainOutput();

    $display("errors: %0d, flits sent: %0d, flits checked: %0d", errors, txCount, rxCount);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES)
      @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("errors: %0d, flits sent: %0d, flits checked: %0d", errors, txCount, rxCount);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- nocRouterOut.f
+incdir+common
common/nocFlitPkg.sv
common/nocArbPkg.sv
hw/inputPort.sv
arbiter/switchArbiter.sv
hw/outputLink.sv
hw/nocRouterOut.sv
verif/tbNocRouterOut.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbNocRouterOut
RTL_TOP   ?= nocRouterOut
FILELIST  ?= nocRouterOut.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The run fails unless the pass line shows up in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
